// ==== burst_mapper.f ====
+incdir+hdl
hdl/burst_pkg.sv
hdl/axi_chan_pkg.sv
hdl/burst_gearbox.sv
hdl/request_splitter.sv
hdl/wlast_fixup.sv
hdl/response_filter.sv
hdl/burst_mapper.sv
verif/burst_mapper_tb.sv

// ==== verif/burst_mapper_vectors.txt ====
# op (R or W), first line address (hex), source burst beats, expected sink bursts
# Writes come first so that the reads below can check the stored data
W 0000000 1 1
W 0000001 3 2
W 0000010 16 1
W 0000020 32 2
W 0000043 20 6
W 0000100 256 16
W 000023D 9 4
W 00003FF 2 2
W 00001F8 100 8
W 2ABCDE7 7 3
W 0000400 255 19
W 00000C1 17 5
W 000007F 1 1
R 0000000 1 1
R 0000001 3 2
R 0000000 48 3
R 0000043 20 6
R 0000100 256 16
R 000023D 9 4
R 00003FF 2 2
R 00001F8 100 8
R 2ABCDE7 7 3
R 0000400 255 19
R 0000800 5 2
R 00000C1 17 5
R 000007F 1 1

// ==== verif/burst_mapper_tb.sv ====
`timescale 1ns/1ns

module burst_mapper_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int PAGE_LINES  = 64;
    // Direct-mapped line store, indexed by the low address bits and tagged
    localparam int STORE_LINES = 4096;
    localparam int REF_BANK    = 0;
    localparam int SINK_BANK   = 1;

    logic                    clk;
    logic                    reset_n;
    axi_chan_pkg::src_req_t  src_ar;
    logic                    src_arvalid;
    logic                    src_arready;
    axi_chan_pkg::src_req_t  src_aw;
    logic                    src_awvalid;
    logic                    src_awready;
    axi_chan_pkg::wbeat_t    src_w;
    logic                    src_wvalid;
    logic                    src_wready;
    axi_chan_pkg::rbeat_t    src_r;
    logic                    src_rvalid;
    logic                    src_rready;
    axi_chan_pkg::bresp_t    src_b;
    logic                    src_bvalid;
    logic                    src_bready;
    axi_chan_pkg::sink_req_t sink_ar;
    logic                    sink_arvalid;
    logic                    sink_arready;
    axi_chan_pkg::sink_req_t sink_aw;
    logic                    sink_awvalid;
    logic                    sink_awready;
    axi_chan_pkg::wbeat_t    sink_w;
    logic                    sink_wvalid;
    logic                    sink_wready;
    axi_chan_pkg::rbeat_t    sink_r;
    logic                    sink_rvalid;
    logic                    sink_rready;
    axi_chan_pkg::bresp_t    sink_b;
    logic                    sink_bvalid;
    logic                    sink_bready;

    // Bank 0 is what the source wrote, bank 1 is what reached the sink
    burst_pkg::data_t        store_data  [2][STORE_LINES];
    burst_pkg::line_addr_t   store_tag   [2][STORE_LINES];
    bit                      store_valid [2][STORE_LINES];

    // Vectors as read from the file
    byte                     op_q     [$];
    burst_pkg::line_addr_t   addr_q   [$];
    int                      beats_q  [$];
    int                      bursts_q [$];
    int                      watchdog_cycles;
    bit                      vectors_ready = 1'b0;

    // The source burst in flight and what the sink side has seen of it
    bit                      cur_write;
    burst_pkg::line_addr_t   cur_base;
    burst_pkg::txn_id_t      cur_id;
    int                      cur_beats;
    burst_pkg::line_addr_t   exp_addr;
    int                      remaining;
    int                      burst_cnt;
    int                      r_seen;
    int                      b_seen;

    // Sink model queues and return channel state
    axi_chan_pkg::sink_req_t rd_pend [$];
    axi_chan_pkg::sink_req_t wr_pend [$];
    axi_chan_pkg::bresp_t    b_pend  [$];
    axi_chan_pkg::sink_req_t r_cur;
    int                      r_idx    = 0;
    bit                      r_active = 1'b0;
    axi_chan_pkg::bresp_t    b_cur;
    bit                      b_active = 1'b0;
    int                      w_idx    = 0;

    burst_mapper i_burst_mapper (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Unwritten lines read back as a pattern built from the full address
    function automatic burst_pkg::data_t line_pattern(burst_pkg::line_addr_t a);
        return burst_pkg::data_t'({~a, 6'h2d, a});
    endfunction

    function automatic burst_pkg::data_t read_line(int bank, burst_pkg::line_addr_t a);
        int idx;
        idx = int'(a % STORE_LINES);
        if (store_valid[bank][idx] && store_tag[bank][idx] == a)
        begin
            return store_data[bank][idx];
        end
        return line_pattern(a);
    endfunction

    task automatic write_line(input int bank, input burst_pkg::line_addr_t a,
                              input burst_pkg::data_t d);
        int idx;
        idx = int'(a % STORE_LINES);
        store_data[bank][idx]  = d;
        store_tag[bank][idx]   = a;
        store_valid[bank][idx] = 1'b1;
    endtask

    // Largest power of two up to 16 beats that fits n and divides a
    function automatic int sink_size(burst_pkg::line_addr_t a, int n);
        int size;
        size = 16;
        while (size > n || (a % size) != 0)
        begin
            size = size / 2;
        end
        return size;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "Value check failed");
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("STATUS: FAIL");
        $fatal(1, "Run aborted");
    endtask

    // Each sink request must be the next piece that the splitting rule gives
    task automatic check_sink_req(input axi_chan_pkg::sink_req_t req, input bit is_write);
        string chan;
        int    size;
        chan = is_write ? "sink_aw" : "sink_ar";
        if (is_write != cur_write)
        begin
            abort_run({chan, " carried a request while the other direction was active"});
        end
        if (remaining <= 0)
        begin
            abort_run({chan, " carried a request past the end of the source burst"});
        end
        size = sink_size(exp_addr, remaining);
        check_eq({chan, ".addr"}, req.addr, exp_addr);
        check_eq({chan, ".len"}, req.len, size - 1);
        check_eq({chan, ".id"}, req.id, cur_id);
        check_eq({chan, ".no_reply"}, req.no_reply, remaining != size);
        check_eq({chan, " page crossing"}, (req.addr % PAGE_LINES) + req.len + 1 > PAGE_LINES, 0);
        exp_addr = burst_pkg::line_addr_t'(exp_addr + size);
        remaining -= size;
        burst_cnt++;
    endtask

    // Sink write beat lands at the head request's next line
    task automatic take_sink_wbeat();
        axi_chan_pkg::sink_req_t head;
        axi_chan_pkg::bresp_t    resp;
        burst_pkg::line_addr_t   addr;
        if (wr_pend.size() == 0)
        begin
            abort_run("Write data reached the sink ahead of its burst request");
        end
        head = wr_pend[0];
        addr = burst_pkg::line_addr_t'(head.addr + w_idx);
        check_eq("sink_w.data", sink_w.data, read_line(REF_BANK, addr));
        check_eq("sink_w.last", sink_w.last, w_idx == head.len);
        write_line(SINK_BANK, addr, sink_w.data);
        if (w_idx == head.len)
        begin
            resp.id       = head.id;
            resp.no_reply = head.no_reply;
            b_pend.push_back(resp);
            head  = wr_pend.pop_front();
            w_idx = 0;
        end
        else
        begin
            w_idx++;
        end
    endtask

    // Sink side handshakes
    always @(posedge clk)
    begin
        if (reset_n)
        begin
            if (sink_arvalid && sink_arready)
            begin
                check_sink_req(sink_ar, 1'b0);
                rd_pend.push_back(sink_ar);
            end
            if (sink_awvalid && sink_awready)
            begin
                check_sink_req(sink_aw, 1'b1);
                wr_pend.push_back(sink_aw);
            end
            if (sink_wvalid && sink_wready)
            begin
                take_sink_wbeat();
            end
            if (sink_rvalid && sink_rready)
            begin
                if (r_idx == r_cur.len)
                begin
                    r_active = 1'b0;
                end
                r_idx++;
            end
            if (sink_bvalid && sink_bready)
            begin
                b_active = 1'b0;
            end
        end
    end

    // Source side responses, last only where the source burst really ends
    always @(posedge clk)
    begin
        if (reset_n)
        begin
            if (src_rvalid && src_rready)
            begin
                if (cur_write || r_seen >= cur_beats)
                begin
                    abort_run("Read data reached the source with no read beat pending");
                end
                check_eq("src_r.data", src_r.data,
                         read_line(REF_BANK, burst_pkg::line_addr_t'(cur_base + r_seen)));
                check_eq("src_r.id", src_r.id, cur_id);
                check_eq("src_r.last", src_r.last, r_seen == cur_beats - 1);
                check_eq("src_r.no_reply", src_r.no_reply, 0);
                r_seen++;
            end
            if (src_bvalid && src_bready)
            begin
                if (!cur_write)
                begin
                    abort_run("A write response reached the source during a read");
                end
                check_eq("src_b.id", src_b.id, cur_id);
                check_eq("src_b.no_reply", src_b.no_reply, 0);
                b_seen++;
            end
        end
    end

    // Random stalls and the sink's return channels change on falling edges
    initial
    begin : sink_drive
        void'($urandom(68));
        forever
        begin
            @(negedge clk);
            sink_arready = ($urandom % 4) != 0;
            sink_awready = ($urandom % 4) != 0;
            sink_wready  = ($urandom % 4) != 0;
            src_rready   = ($urandom % 4) != 0;
            src_bready   = ($urandom % 4) != 0;
            if (!r_active && rd_pend.size() > 0)
            begin
                r_cur    = rd_pend.pop_front();
                r_idx    = 0;
                r_active = 1'b1;
            end
            sink_rvalid = r_active;
            // The sink echoes no_reply into every beat of the burst
            sink_r = '{data: read_line(SINK_BANK, burst_pkg::line_addr_t'(r_cur.addr + r_idx)),
                       id: r_cur.id, last: r_idx == r_cur.len, no_reply: r_cur.no_reply};
            if (!b_active && b_pend.size() > 0)
            begin
                b_cur    = b_pend.pop_front();
                b_active = 1'b1;
            end
            sink_bvalid = b_active;
            sink_b      = b_cur;
        end
    end

    task automatic send_request(input bit is_write, input axi_chan_pkg::src_req_t req);
        @(negedge clk);
        if (is_write)
        begin
            src_aw      = req;
            src_awvalid = 1'b1;
        end
        else
        begin
            src_ar      = req;
            src_arvalid = 1'b1;
        end
        @(posedge clk);
        while (!(is_write ? src_awready : src_arready))
        begin
            @(posedge clk);
        end
        @(negedge clk);
        src_awvalid = 1'b0;
        src_arvalid = 1'b0;
    endtask

    task automatic send_wdata(input burst_pkg::line_addr_t addr, input int beats);
        burst_pkg::data_t data;
        for (int k = 0; k < beats; k++)
        begin
            data = {$urandom, $urandom};
            @(negedge clk);
            write_line(REF_BANK, burst_pkg::line_addr_t'(addr + k), data);
            src_w      = '{data: data, last: k == beats - 1};
            src_wvalid = 1'b1;
            @(posedge clk);
            while (!src_wready)
            begin
                @(posedge clk);
            end
        end
        @(negedge clk);
        src_wvalid = 1'b0;
    endtask

    // Address and data run side by side since data waits for sink lengths
    task automatic run_write(input axi_chan_pkg::src_req_t req, input int beats);
        fork
            send_request(1'b1, req);
            send_wdata(req.addr, beats);
        join
        // The final sink response comes back last, so once every sink burst
        // has answered and the filter stage is empty nothing more can follow
        while (b_seen < 1 || remaining != 0 || wr_pend.size() != 0 || b_pend.size() != 0
               || b_active || src_bvalid)
        begin
            @(negedge clk);
        end
        check_eq("source write response count", b_seen, 1);
    endtask

    task automatic run_read(input axi_chan_pkg::src_req_t req, input int beats);
        send_request(1'b0, req);
        while (r_seen < beats)
        begin
            @(negedge clk);
        end
    endtask

    initial
    begin : watchdog
        wait (vectors_ready);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run("Timeout, the vectors did not complete in time");
    end

    initial
    begin : main_flow
        int                     fd;
        string                  line;
        byte                    op;
        int                     a;
        int                     beats;
        int                     bursts;
        int                     total_beats;
        axi_chan_pkg::src_req_t req;
        reset_n      = 1'b0;
        src_ar       = '0;
        src_arvalid  = 1'b0;
        src_aw       = '0;
        src_awvalid  = 1'b0;
        src_w        = '0;
        src_wvalid   = 1'b0;
        src_rready   = 1'b0;
        src_bready   = 1'b0;
        sink_arready = 1'b0;
        sink_awready = 1'b0;
        sink_wready  = 1'b0;
        sink_r       = '0;
        sink_rvalid  = 1'b0;
        sink_b       = '0;
        sink_bvalid  = 1'b0;
        r_cur        = '0;
        b_cur        = '0;
        total_beats  = 0;
        fd = $fopen("verif/burst_mapper_vectors.txt", "r");
        if (fd == 0)
        begin
            abort_run("Cannot open the vector file");
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() > 1 && line[0] != "#")
            begin
                if ($sscanf(line, "%c %h %d %d", op, a, beats, bursts) != 4)
                begin
                    abort_run({"Malformed vector line: ", line});
                end
                op_q.push_back(op);
                addr_q.push_back(burst_pkg::line_addr_t'(a));
                beats_q.push_back(beats);
                bursts_q.push_back(bursts);
                total_beats += beats;
            end
        end
        $fclose(fd);
        // Twenty cycles per beat plus some slack for reset
        watchdog_cycles = total_beats * 20 + 100;
        vectors_ready   = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        check_eq("sink_arvalid after reset", sink_arvalid, 0);
        check_eq("sink_awvalid after reset", sink_awvalid, 0);
        check_eq("sink_wvalid after reset", sink_wvalid, 0);
        check_eq("src_rvalid after reset", src_rvalid, 0);
        check_eq("src_bvalid after reset", src_bvalid, 0);

        for (int i = 0; i < op_q.size(); i++)
        begin
            cur_write = (op_q[i] == "W");
            cur_base  = addr_q[i];
            cur_id    = burst_pkg::txn_id_t'(i);
            cur_beats = beats_q[i];
            exp_addr  = addr_q[i];
            remaining = beats_q[i];
            burst_cnt = 0;
            r_seen    = 0;
            b_seen    = 0;
            req.addr  = addr_q[i];
            req.len   = burst_pkg::src_len_t'(beats_q[i] - 1);
            req.id    = cur_id;
            if (op_q[i] == "W")
            begin
                run_write(req, beats_q[i]);
            end
            else if (op_q[i] == "R")
            begin
                run_read(req, beats_q[i]);
            end
            else
            begin
                abort_run("Vector operation is neither R nor W");
            end
            check_eq("sink burst count", burst_cnt, bursts_q[i]);
            check_eq("beats left unissued", remaining, 0);
        end

        repeat (4) @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== hdl/burst_mapper.sv ====
`timescale 1ns/1ns

module burst_mapper
(
    input  logic                    clk,
    input  logic                    reset_n,
    // Source side
    input  axi_chan_pkg::src_req_t  src_ar,
    input  logic                    src_arvalid,
    output logic                    src_arready,
    input  axi_chan_pkg::src_req_t  src_aw,
    input  logic                    src_awvalid,
    output logic                    src_awready,
    input  axi_chan_pkg::wbeat_t    src_w,
    input  logic                    src_wvalid,
    output logic                    src_wready,
    output axi_chan_pkg::rbeat_t    src_r,
    output logic                    src_rvalid,
    input  logic                    src_rready,
    output axi_chan_pkg::bresp_t    src_b,
    output logic                    src_bvalid,
    input  logic                    src_bready,
    // Sink side
    output axi_chan_pkg::sink_req_t sink_ar,
    output logic                    sink_arvalid,
    input  logic                    sink_arready,
    output axi_chan_pkg::sink_req_t sink_aw,
    output logic                    sink_awvalid,
    input  logic                    sink_awready,
    output axi_chan_pkg::wbeat_t    sink_w,
    output logic                    sink_wvalid,
    input  logic                    sink_wready,
    input  axi_chan_pkg::rbeat_t    sink_r,
    input  logic                    sink_rvalid,
    output logic                    sink_rready,
    input  axi_chan_pkg::bresp_t    sink_b,
    input  logic                    sink_bvalid,
    output logic                    sink_bready
);

    logic aw_valid_raw;
    logic fifo_full;

    request_splitter rd_split
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .src_req    (src_ar),
        .src_valid  (src_arvalid),
        .src_ready  (src_arready),
        .sink_req   (sink_ar),
        .sink_valid (sink_arvalid),
        .sink_ready (sink_arready)
    );

    // A write burst may only leave once its length has room in the fixup queue
    request_splitter wr_split
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .src_req    (src_aw),
        .src_valid  (src_awvalid),
        .src_ready  (src_awready),
        .sink_req   (sink_aw),
        .sink_valid (aw_valid_raw),
        .sink_ready (sink_awready && !fifo_full)
    );

    // Full only rises on a push, so a shown request cannot be withdrawn
    assign sink_awvalid = aw_valid_raw && !fifo_full;

    wlast_fixup i_wlast_fixup
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .aw_len      (sink_aw.len),
        .aw_push     (sink_awvalid && sink_awready),
        .fifo_full   (fifo_full),
        .src_w       (src_w),
        .src_wvalid  (src_wvalid),
        .src_wready  (src_wready),
        .sink_w      (sink_w),
        .sink_wvalid (sink_wvalid),
        .sink_wready (sink_wready)
    );

    response_filter i_response_filter
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .ar_done     (src_arvalid && src_arready),
        .aw_done     (src_awvalid && src_awready),
        .sink_r      (sink_r),
        .sink_rvalid (sink_rvalid),
        .sink_rready (sink_rready),
        .src_r       (src_r),
        .src_rvalid  (src_rvalid),
        .src_rready  (src_rready),
        .sink_b      (sink_b),
        .sink_bvalid (sink_bvalid),
        .sink_bready (sink_bready),
        .src_b       (src_b),
        .src_bvalid  (src_bvalid),
        .src_bready  (src_bready)
    );

endmodule

// ==== hdl/response_filter.sv ====
`timescale 1ns/1ns

module response_filter
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 ar_done,
    input  logic                 aw_done,
    input  axi_chan_pkg::rbeat_t sink_r,
    input  logic                 sink_rvalid,
    output logic                 sink_rready,
    output axi_chan_pkg::rbeat_t src_r,
    output logic                 src_rvalid,
    input  logic                 src_rready,
    input  axi_chan_pkg::bresp_t sink_b,
    input  logic                 sink_bvalid,
    output logic                 sink_bready,
    output axi_chan_pkg::bresp_t src_b,
    output logic                 src_bvalid,
    input  logic                 src_bready
);

    logic [31:0] rd_req_cnt;
    logic [31:0] rd_resp_cnt;
    logic [31:0] wr_req_cnt;
    logic [31:0] wr_resp_cnt;

    // Both channels are a plain pipeline stage that stalls with the source
    assign sink_rready = src_rready;
    assign sink_bready = src_bready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            src_rvalid <= 1'b0;
            src_bvalid <= 1'b0;
        end
        else
        begin
            if (src_rready)
            begin
                src_rvalid <= sink_rvalid;
            end
            // Responses to injected write bursts vanish here
            if (src_bready)
            begin
                src_bvalid <= sink_bvalid && !sink_b.no_reply;
            end
        end
    end

    // The source never sees no_reply, and sees last only at its own burst end
    always_ff @(posedge clk)
    begin
        if (src_rready)
        begin
            src_r <= '{data: sink_r.data, id: sink_r.id,
                       last: sink_r.last && !sink_r.no_reply, no_reply: 1'b0};
        end
        if (src_bready)
        begin
            src_b <= '{id: sink_b.id, no_reply: 1'b0};
        end
    end

    // Source requests against completed source responses
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_req_cnt  <= '0;
            rd_resp_cnt <= '0;
            wr_req_cnt  <= '0;
            wr_resp_cnt <= '0;
        end
        else
        begin
            rd_req_cnt  <= rd_req_cnt + 32'(ar_done);
            wr_req_cnt  <= wr_req_cnt + 32'(aw_done);
            rd_resp_cnt <= rd_resp_cnt + 32'(src_rvalid && src_rready && src_r.last);
            wr_resp_cnt <= wr_resp_cnt + 32'(src_bvalid && src_bready);
        end
    end

    // More responses than requests means the sink lost the no_reply echo
    a_rd_resp_bound: assert property (@(posedge clk) disable iff (!reset_n)
        rd_resp_cnt <= rd_req_cnt);
    a_wr_resp_bound: assert property (@(posedge clk) disable iff (!reset_n)
        wr_resp_cnt <= wr_req_cnt);

endmodule

// ==== hdl/wlast_fixup.sv ====
`timescale 1ns/1ns

`include "burst_map_params.svh"

module wlast_fixup
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  burst_pkg::sink_len_t aw_len,
    input  logic                 aw_push,
    output logic                 fifo_full,
    input  axi_chan_pkg::wbeat_t src_w,
    input  logic                 src_wvalid,
    output logic                 src_wready,
    output axi_chan_pkg::wbeat_t sink_w,
    output logic                 sink_wvalid,
    input  logic                 sink_wready
);

    localparam int DEPTH = `BM_WLEN_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    burst_pkg::sink_len_t len_mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    burst_pkg::sink_len_t beat_cnt;
    logic                 fifo_empty;
    logic                 out_adv;
    logic                 load;
    logic                 beat_end;
    logic                 pop;

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == CNT_W'(DEPTH));

    // Output register is free when empty or draining this cycle
    assign out_adv = !sink_wvalid || sink_wready;
    // Source data waits until the length of its sink burst is known
    assign src_wready = !fifo_empty && out_adv;
    assign load       = src_wvalid && src_wready;
    // This beat closes the burst at the head of the FIFO
    assign beat_end   = (beat_cnt == len_mem[rd_ptr]);
    assign pop        = load && beat_end;

    always_ff @(posedge clk)
    begin
        if (aw_push)
        begin
            len_mem[wr_ptr] <= aw_len;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            beat_cnt    <= '0;
            sink_wvalid <= 1'b0;
        end
        else
        begin
            if (aw_push)
            begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            if (aw_push && !pop)
            begin
                count <= count + CNT_W'(1);
            end
            else if (pop && !aw_push)
            begin
                count <= count - CNT_W'(1);
            end
            if (load)
            begin
                beat_cnt <= beat_end ? '0 : beat_cnt + 1'b1;
            end
            if (out_adv)
            begin
                sink_wvalid <= load;
            end
        end
    end

    // The source last flag is replaced by the sink burst boundary
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            sink_w <= '{data: src_w.data, last: beat_end};
        end
    end

    // The top level must hold back sink aw while the length queue is full
    a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
        aw_push |-> !fifo_full);

endmodule

// ==== hdl/request_splitter.sv ====
`timescale 1ns/1ns

module request_splitter
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  axi_chan_pkg::src_req_t  src_req,
    input  logic                   src_valid,
    output logic                   src_ready,
    output axi_chan_pkg::sink_req_t sink_req,
    output logic                   sink_valid,
    input  logic                   sink_ready
);

    logic                  new_req;
    logic                  accept;
    logic                  last_burst;
    burst_pkg::line_addr_t burst_addr;
    burst_pkg::sink_len_t  burst_len;
    burst_pkg::txn_id_t    id_q;

    // Take a new source burst once nothing is pending or the pending sink
    // burst is the final piece of the current one and it is leaving now
    assign src_ready = sink_ready && (!sink_valid || last_burst);
    assign new_req   = src_valid && src_ready;
    assign accept    = sink_valid && sink_ready;

    burst_gearbox i_gearbox
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .new_req    (new_req),
        .req_addr   (src_req.addr),
        .req_len    (src_req.len),
        .accept     (accept),
        .last_burst (last_burst),
        .burst_addr (burst_addr),
        .burst_len  (burst_len)
    );

    // Sink valid only falls after the final piece when no new burst follows
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sink_valid <= 1'b0;
        end
        else if (src_ready)
        begin
            sink_valid <= src_valid;
        end
    end

    // The id is the only source field the gearbox does not track
    always_ff @(posedge clk)
    begin
        if (new_req)
        begin
            id_q <= src_req.id;
        end
    end

    // Injected bursts are every piece but the last one
    assign sink_req = '{addr: burst_addr, len: burst_len, id: id_q, no_reply: !last_burst};

    // A stalled sink request holds both its valid and its payload
    a_req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (sink_valid && !sink_ready) |=> (sink_valid && $stable(sink_req)));

endmodule

// ==== hdl/burst_gearbox.sv ====
`timescale 1ns/1ns

`include "burst_map_params.svh"

module burst_gearbox
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  new_req,
    input  burst_pkg::line_addr_t req_addr,
    input  burst_pkg::src_len_t   req_len,
    input  logic                  accept,
    output logic                  last_burst,
    output burst_pkg::line_addr_t burst_addr,
    output burst_pkg::sink_len_t  burst_len
);

    // Remaining beats are counted directly, so one extra bit holds 256
    typedef logic [`BM_SRC_LEN_W:0] rem_t;

    burst_pkg::gearbox_state_t state_q;
    burst_pkg::line_addr_t     addr_q;
    rem_t                      remain_q;
    rem_t                      size;

    // Does a burst of 2**lg beats fit the remaining count, the alignment
    // rule and the page boundary when it starts at address a
    function automatic logic burst_fits(burst_pkg::line_addr_t a, rem_t n, int unsigned lg);
        rem_t beats;
        logic aligned;
        logic in_page;
        beats = rem_t'(1) << lg;
        aligned = (`BM_NATURAL_ALIGN == 0) ||
                  ((a & burst_pkg::line_addr_t'(beats - rem_t'(1))) == '0);
        // With natural alignment this never trips, it matters only without it
        in_page = ((a % `BM_PAGE_LINES) + beats) <= `BM_PAGE_LINES;
        return (beats <= n) && aligned && in_page;
    endfunction

    // Fit conditions are monotonic in size, so walking upward and keeping
    // the last size that fits picks the largest legal burst
    always_comb
    begin
        size = rem_t'(1);
        for (int unsigned i = 1; i <= `BM_SINK_LEN_W; i++)
        begin
            if (burst_fits(addr_q, remain_q, i))
            begin
                size = rem_t'(1) << i;
            end
        end
    end

    assign burst_addr = addr_q;
    assign burst_len  = burst_pkg::sink_len_t'(size - rem_t'(1));
    // The current burst drains everything that is left of the source burst
    assign last_burst = (state_q == burst_pkg::GB_SPLIT) && (remain_q == size);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state_q  <= burst_pkg::GB_IDLE;
            remain_q <= '0;
        end
        else if (new_req)
        begin
            // A new source burst may arrive in the cycle the last sink burst goes
            state_q  <= burst_pkg::GB_SPLIT;
            remain_q <= rem_t'(req_len) + rem_t'(1);
        end
        else if (accept)
        begin
            remain_q <= remain_q - size;
            if (last_burst)
            begin
                state_q <= burst_pkg::GB_IDLE;
            end
        end
    end

    // Address only moves with a request or an accepted burst
    always_ff @(posedge clk)
    begin
        if (new_req)
        begin
            addr_q <= req_addr;
        end
        else if (accept)
        begin
            addr_q <= addr_q + burst_pkg::line_addr_t'(size);
        end
    end

    // Every emitted burst starts on a multiple of its own size
    a_burst_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        (state_q == burst_pkg::GB_SPLIT && `BM_NATURAL_ALIGN != 0) |->
        ((burst_addr & burst_pkg::line_addr_t'(burst_len)) == '0));

endmodule

// ==== hdl/axi_chan_pkg.sv ====
package axi_chan_pkg;

    // Request as issued by the source, may span up to 256 beats
    typedef struct packed {
        burst_pkg::line_addr_t addr;
        burst_pkg::src_len_t   len;
        burst_pkg::txn_id_t    id;
    } src_req_t;

    // Request as seen by the sink
    // No_reply marks bursts injected by the mapper, i.e. every sink burst
    // except the one that finishes a source burst
    typedef struct packed {
        burst_pkg::line_addr_t addr;
        burst_pkg::sink_len_t  len;
        burst_pkg::txn_id_t    id;
        logic                  no_reply;
    } sink_req_t;

    // Write data beat, last closes a burst
    typedef struct packed {
        burst_pkg::data_t data;
        logic             last;
    } wbeat_t;

    // Read data beat
    // The sink copies no_reply from the request into each beat
    typedef struct packed {
        burst_pkg::data_t   data;
        burst_pkg::txn_id_t id;
        logic               last;
        logic               no_reply;
    } rbeat_t;

    // Write response, one per sink write burst
    typedef struct packed {
        burst_pkg::txn_id_t id;
        logic               no_reply;
    } bresp_t;

endpackage

// ==== hdl/burst_pkg.sv ====
`include "burst_map_params.svh"

package burst_pkg;

    // Line index into memory
    typedef logic [`BM_ADDR_W-1:0] line_addr_t;

    // Burst lengths, both held as beats minus one
    typedef logic [`BM_SRC_LEN_W-1:0] src_len_t;
    typedef logic [`BM_SINK_LEN_W-1:0] sink_len_t;

    // One beat of read or write data
    typedef logic [`BM_DATA_W-1:0] data_t;

    // Transaction id, returned with every response
    typedef logic [`BM_ID_W-1:0] txn_id_t;

    // The gearbox is either waiting for a source burst or emitting sink bursts
    typedef enum logic {
        GB_IDLE,
        GB_SPLIT
    } gearbox_state_t;

endpackage

// ==== hdl/burst_map_params.svh ====
`ifndef BURST_MAP_PARAMS_SVH
`define BURST_MAP_PARAMS_SVH

// Line address width, addresses count whole data lines
`define BM_ADDR_W 26

// Source burst length field, stored as beats minus one (up to 256 beats)
`define BM_SRC_LEN_W 8

// Sink burst length field, stored as beats minus one (up to 16 beats)
`define BM_SINK_LEN_W 4

// Width of one data beat
`define BM_DATA_W 64

// Transaction id width
`define BM_ID_W 4

// Sink bursts never cross a page of this many lines
`define BM_PAGE_LINES 64

// Set to 1 when sink bursts must start on a multiple of their own size
`define BM_NATURAL_ALIGN 1

// Number of sink write burst lengths the write-last fixup can queue
`define BM_WLEN_FIFO_DEPTH 4

`endif
